// ==== compile.f ====
+incdir+hdl
hdl/sdram_pkg.sv
hdl/sdram_bank.sv
hdl/sdram_device.sv
hdl/sdram_ctrl.sv
hdl/sdram_subsys.sv
tb/sdram_subsys_tb.sv

// ==== hdl/sdram_bank.sv ====
`include "sdram_settings.svh"

module sdram_bank
    import sdram_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  sdram_cmd_e                  cmd,
    input  logic                        sel,
    input  logic [`SDRAM_ADDR_BITS-1:0] addr,
    input  logic [2:0]                  cas_lat,
    input  logic [3:0]                  burst_len,
    input  logic                        all_banks,
    output logic [`SDRAM_ROW_BITS-1:0]  row,
    output logic [`SDRAM_COL_BITS-1:0]  col,
    output bank_state_e                 state,
    output logic                        rd_fire,
    output logic                        wr_fire
);

    logic                       open_flag;
    logic [2:0]                 delay_cnt;
    logic [3:0]                 burst_cnt;
    logic [`SDRAM_COL_BITS-1:0] cur_col;
    logic                       rd_cmd;
    logic                       wr_cmd;

    assign rd_cmd = sel && cmd == CMD_READ;
    assign wr_cmd = sel && cmd == CMD_WRITE;

    // Word 0 of a write lands on the command edge, column straight from the pins
    assign wr_fire = wr_cmd || state == BANK_WRITING;
    assign rd_fire = state == BANK_READING;
    assign col     = wr_cmd ? addr[`SDRAM_COL_BITS-1:0] : cur_col;

    // Open-row flag, cleared by precharge of this bank or of all banks
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            open_flag <= 1'b0;
        end else if (sel && cmd == CMD_ACTIVE) begin
            open_flag <= 1'b1;
        end else if (cmd == CMD_PRECHARGE && (sel || all_banks)) begin
            open_flag <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (sel && cmd == CMD_ACTIVE) begin
            row <= addr[`SDRAM_ROW_BITS-1:0];
        end
    end

    // Burst FSM
    // WAIT_READ lasts CL-1 cycles, device registers dq one more, so CL >= 2
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= BANK_IDLE;
            delay_cnt <= '0;
            burst_cnt <= '0;
        end else if (rd_cmd) begin
            state     <= BANK_WAIT_READ;
            delay_cnt <= cas_lat - 3'd2;
            burst_cnt <= burst_len - 4'd1;
        end else if (wr_cmd) begin
            // Single-word burst is already done on the command edge
            state     <= (burst_len > 4'd1) ? BANK_WRITING : BANK_IDLE;
            burst_cnt <= burst_len - 4'd2;
        end else begin
            case (state)
                BANK_WAIT_READ: begin
                    if (delay_cnt == 3'd0) begin
                        state <= BANK_READING;
                    end else begin
                        delay_cnt <= delay_cnt - 3'd1;
                    end
                end
                BANK_READING, BANK_WRITING: begin
                    if (burst_cnt == 4'd0) begin
                        state <= BANK_IDLE;
                    end else begin
                        burst_cnt <= burst_cnt - 4'd1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Column walks one step per moved word
    always_ff @(posedge clk) begin
        if (rd_cmd) begin
            cur_col <= addr[`SDRAM_COL_BITS-1:0];
        end else if (wr_cmd) begin
            cur_col <= addr[`SDRAM_COL_BITS-1:0] + 1'b1;
        end else if (rd_fire || state == BANK_WRITING) begin
            cur_col <= cur_col + 1'b1;
        end
    end

    // Controller must have opened the row with ACTIVE first
    a_col_cmd_open: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_cmd || wr_cmd) |-> open_flag)
        else $error("READ or WRITE to a bank with no open row");

endmodule

// ==== hdl/sdram_ctrl.sv ====
`include "sdram_settings.svh"

module sdram_ctrl
    import sdram_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  logic                          req_write,
    input  logic [`SDRAM_BA_BITS-1:0]     req_bank,
    input  logic [`SDRAM_ROW_BITS-1:0]    req_row,
    input  logic [`SDRAM_COL_BITS-1:0]    req_col,
    input  logic [`SDRAM_DQ_BITS/8-1:0]   req_mask,
    input  logic [`SDRAM_DQ_BITS-1:0]     wr_data,
    output logic                          wr_next,
    output logic                          rd_valid,
    output logic [`SDRAM_DQ_BITS-1:0]     rd_data,
    output logic                          busy,
    output logic                          init_done,
    output logic                          cs,
    output logic                          ras,
    output logic                          cas,
    output logic                          we,
    output logic [`SDRAM_ADDR_BITS-1:0]   a,
    output logic [`SDRAM_BA_BITS-1:0]     ba,
    output logic [`SDRAM_DQ_BITS/8-1:0]   dqm,
    inout  wire  [`SDRAM_DQ_BITS-1:0]     dq
);

    localparam int WORD_W = $clog2(`SDRAM_BURST);
    localparam logic [WORD_W-1:0] LAST_WORD = WORD_W'(`SDRAM_BURST - 1);
    // CAS latency in a[6:4], sequential burst, burst code in a[2:0]
    localparam logic [`SDRAM_ADDR_BITS-1:0] MODE_WORD =
        `SDRAM_ADDR_BITS'({3'(`SDRAM_CAS_LAT), 1'b0, 3'($clog2(`SDRAM_BURST))});
    localparam logic [`SDRAM_ADDR_BITS-1:0] ALL_BANKS = `SDRAM_ADDR_BITS'(1 << 10);

    ctrl_state_e                  state;
    sdram_cmd_e                   cmd_q;
    logic [7:0]                   cnt;
    logic                         cnt_done;
    logic [WORD_W-1:0]            words;
    logic                         write_q;
    logic [`SDRAM_COL_BITS-1:0]   col_q;
    logic [`SDRAM_DQ_BITS/8-1:0]  mask_q;
    logic [`SDRAM_DQ_BITS-1:0]    dq_out;
    logic                         dq_en;

    assign cnt_done = cnt == 8'd0;
    assign {cs, ras, cas, we} = cmd_q;
    assign dq = dq_en ? dq_out : 'z;

    // High in each cycle whose closing edge takes wr_data
    assign wr_next = (state == ST_ACTIVATE && cnt_done && write_q) || state == ST_WRITE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_INIT_WAIT;
            cnt       <= 8'(`SDRAM_INIT_CYCLES - 1);
            words     <= '0;
            cmd_q     <= CMD_NOP;
            dq_en     <= 1'b0;
            busy      <= 1'b0;
            init_done <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            cmd_q    <= CMD_NOP;
            rd_valid <= 1'b0;
            // Free-running wait timer, reloaded per state
            if (!cnt_done) begin
                cnt <= cnt - 8'd1;
            end
            case (state)
                ST_INIT_WAIT: if (cnt_done) begin
                    cmd_q <= CMD_PRECHARGE;
                    a     <= ALL_BANKS;
                    cnt   <= 8'(`SDRAM_TRP - 1);
                    state <= ST_INIT_PRE;
                end
                ST_INIT_PRE: if (cnt_done) begin
                    cmd_q <= CMD_REFRESH;
                    cnt   <= 8'(`SDRAM_TRFC - 1);
                    words <= '0;
                    state <= ST_INIT_REF;
                end
                // Word counter doubles as refresh count here
                ST_INIT_REF: if (cnt_done) begin
                    if (words == '0) begin
                        cmd_q <= CMD_REFRESH;
                        cnt   <= 8'(`SDRAM_TRFC - 1);
                        words <= WORD_W'(1);
                    end else begin
                        cmd_q <= CMD_LOAD_MODE;
                        a     <= MODE_WORD;
                        ba    <= '0;
                        cnt   <= 8'(`SDRAM_TMRD - 1);
                        state <= ST_INIT_MODE;
                    end
                end
                ST_INIT_MODE: if (cnt_done) begin
                    init_done <= 1'b1;
                    state     <= ST_IDLE;
                end
                ST_IDLE: if (req) begin
                    cmd_q   <= CMD_ACTIVE;
                    ba      <= req_bank;
                    a       <= `SDRAM_ADDR_BITS'(req_row);
                    write_q <= req_write;
                    col_q   <= req_col;
                    mask_q  <= req_mask;
                    busy    <= 1'b1;
                    cnt     <= 8'(`SDRAM_TRCD - 1);
                    state   <= ST_ACTIVATE;
                end
                // tRCD met, issue the column command with a[10] low
                ST_ACTIVATE: if (cnt_done) begin
                    a <= `SDRAM_ADDR_BITS'(col_q);
                    if (write_q) begin
                        cmd_q  <= CMD_WRITE;
                        dq_out <= wr_data;
                        dq_en  <= 1'b1;
                        dqm    <= mask_q;
                        words  <= WORD_W'(1);
                        state  <= ST_WRITE;
                    end else begin
                        cmd_q <= CMD_READ;
                        dqm   <= '0;
                        words <= '0;
                        // CAS latency, device output register, one edge to sample
                        cnt   <= 8'(`SDRAM_CAS_LAT + 1);
                        state <= ST_READ;
                    end
                end
                ST_WRITE: begin
                    dq_out <= wr_data;
                    words  <= words + 1'b1;
                    if (words == LAST_WORD) begin
                        state <= ST_PRECHARGE;
                    end
                end
                // Timer parks at zero, one word sampled per clock after that
                ST_READ: if (cnt_done) begin
                    rd_data  <= dq;
                    rd_valid <= 1'b1;
                    words    <= words + 1'b1;
                    if (words == LAST_WORD) begin
                        state <= ST_PRECHARGE;
                    end
                end
                ST_PRECHARGE: begin
                    cmd_q <= CMD_PRECHARGE;
                    a     <= '0;
                    dq_en <= 1'b0;
                    cnt   <= 8'(`SDRAM_TRP - 1);
                    state <= ST_DONE;
                end
                ST_DONE: if (cnt_done) begin
                    busy  <= 1'b0;
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_req_allowed: assert property (@(posedge clk) disable iff (!rst_n)
        req |-> (init_done && !busy))
        else $error("request while busy or before init finished");

endmodule

// ==== hdl/sdram_device.sv ====
`include "sdram_settings.svh"

module sdram_device
    import sdram_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cs,
    input  logic                          ras,
    input  logic                          cas,
    input  logic                          we,
    input  logic [`SDRAM_ADDR_BITS-1:0]   a,
    input  logic [`SDRAM_BA_BITS-1:0]     ba,
    input  logic [`SDRAM_DQ_BITS/8-1:0]   dqm,
    inout  wire  [`SDRAM_DQ_BITS-1:0]     dq
);

    localparam int NBANK = `SDRAM_BANKS;
    localparam int NBYTE = `SDRAM_DQ_BITS / 8;
    localparam int IDX_W = `SDRAM_BA_BITS + `SDRAM_ROW_BITS + `SDRAM_COL_BITS;

    sdram_cmd_e                 cmd;
    logic [2:0]                 burst_code;
    logic [2:0]                 cas_lat;
    logic [3:0]                 burst_len;
    logic [`SDRAM_DQ_BITS-1:0]  mem [1 << IDX_W];
    logic [`SDRAM_ROW_BITS-1:0] bank_row [NBANK];
    logic [`SDRAM_COL_BITS-1:0] bank_col [NBANK];
    bank_state_e                bank_state [NBANK];
    logic [NBANK-1:0]           rd_fire;
    logic [NBANK-1:0]           wr_fire;
    logic [IDX_W-1:0]           rd_idx;
    logic [IDX_W-1:0]           wr_idx;
    logic                       rd_busy;
    logic [`SDRAM_DQ_BITS-1:0]  dq_out;
    logic                       dq_en;

    // Pin decode
    // Refresh decodes but has no effect here
    assign cmd = cs ? CMD_INHIBIT : sdram_cmd_e'({1'b0, ras, cas, we});

    // Mode register holds CL2 and BL1 until the first mode load
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            burst_code <= 3'd0;
            cas_lat    <= 3'd2;
        end else if (cmd == CMD_LOAD_MODE) begin
            burst_code <= a[2:0];
            cas_lat    <= a[6:4];
        end
    end

    always_comb begin
        case (burst_code)
            3'd1:    burst_len = 4'd2;
            3'd2:    burst_len = 4'd4;
            3'd3:    burst_len = 4'd8;
            default: burst_len = 4'd1;  // full page not modeled
        endcase
    end

    // Each bank opens and closes its own row
    for (genvar g = 0; g < NBANK; g++) begin : g_bank
        sdram_bank u_bank (
            .clk,
            .rst_n,
            .cmd,
            .sel       (ba == `SDRAM_BA_BITS'(g)),
            .addr      (a),
            .cas_lat,
            .burst_len,
            .all_banks (a[10]),
            .row       (bank_row[g]),
            .col       (bank_col[g]),
            .state     (bank_state[g]),
            .rd_fire   (rd_fire[g]),
            .wr_fire   (wr_fire[g])
        );
    end

    // Storage index of the firing bank
    always_comb begin
        rd_idx  = '0;
        wr_idx  = '0;
        rd_busy = 1'b0;
        for (int i = 0; i < NBANK; i++) begin
            if (rd_fire[i]) begin
                rd_idx = {`SDRAM_BA_BITS'(i), bank_row[i], bank_col[i]};
            end
            if (wr_fire[i]) begin
                wr_idx = {`SDRAM_BA_BITS'(i), bank_row[i], bank_col[i]};
            end
            if (bank_state[i] == BANK_WAIT_READ || bank_state[i] == BANK_READING) begin
                rd_busy = 1'b1;
            end
        end
    end

    // Byte lanes with dqm high keep their old contents
    always_ff @(posedge clk) begin
        if (|wr_fire) begin
            for (int b = 0; b < NBYTE; b++) begin
                if (!dqm[b]) begin
                    mem[wr_idx][b*8 +: 8] <= dq[b*8 +: 8];
                end
            end
        end
    end

    // Read word goes out one clock after its fire cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dq_en <= 1'b0;
        end else begin
            dq_en <= |rd_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (|rd_fire) begin
            dq_out <= mem[rd_idx];
        end
    end

    assign dq = dq_en ? dq_out : 'z;

    a_one_reader: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(rd_fire))
        else $error("more than one bank fires a read");

    // A write while a read is pending or still on dq would fight over the bus
    a_no_write_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        cmd == CMD_WRITE |-> !rd_busy && !dq_en)
        else $error("WRITE issued while a read burst is in flight");

endmodule

// ==== hdl/sdram_pkg.sv ====
package sdram_pkg;

    // Encoded as {cs, ras, cas, we}
    // 4'b0110 is burst terminate, not modeled
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111,
        CMD_INHIBIT   = 4'b1111
    } sdram_cmd_e;

    // Burst state of one device bank
    typedef enum logic [1:0] {
        BANK_IDLE,
        BANK_WAIT_READ,
        BANK_READING,
        BANK_WRITING
    } bank_state_e;

    // Controller sequencer
    typedef enum logic [3:0] {
        ST_INIT_WAIT,
        ST_INIT_PRE,
        ST_INIT_REF,
        ST_INIT_MODE,
        ST_IDLE,
        ST_ACTIVATE,
        ST_WRITE,
        ST_READ,
        ST_PRECHARGE,
        ST_DONE
    } ctrl_state_e;

endpackage

// ==== hdl/sdram_settings.svh ====
`ifndef SDRAM_SETTINGS_SVH
`define SDRAM_SETTINGS_SVH

// Storage geometry, reduced for simulation
`define SDRAM_ROW_BITS     4
`define SDRAM_COL_BITS     5
`define SDRAM_BANKS        4
`define SDRAM_BA_BITS      2

// Pin widths of an x16 part
`define SDRAM_ADDR_BITS    13
`define SDRAM_DQ_BITS      16

// Mode register contents
`define SDRAM_CAS_LAT      2
`define SDRAM_BURST        4

// Command spacing in clocks
`define SDRAM_TRCD         2
`define SDRAM_TRP          2
`define SDRAM_TRFC         4
`define SDRAM_TMRD         2

// Power-up wait before the first command
`define SDRAM_INIT_CYCLES  20

`endif

// ==== hdl/sdram_subsys.sv ====
`include "sdram_settings.svh"

module sdram_subsys (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  logic                          req_write,
    input  logic [`SDRAM_BA_BITS-1:0]     req_bank,
    input  logic [`SDRAM_ROW_BITS-1:0]    req_row,
    input  logic [`SDRAM_COL_BITS-1:0]    req_col,
    input  logic [`SDRAM_DQ_BITS/8-1:0]   req_mask,
    input  logic [`SDRAM_DQ_BITS-1:0]     wr_data,
    output logic                          wr_next,
    output logic                          rd_valid,
    output logic [`SDRAM_DQ_BITS-1:0]     rd_data,
    output logic                          busy,
    output logic                          init_done
);

    // SDRAM pins between controller and device
    logic                         cs;
    logic                         ras;
    logic                         cas;
    logic                         we;
    logic [`SDRAM_ADDR_BITS-1:0]  a;
    logic [`SDRAM_BA_BITS-1:0]    ba;
    logic [`SDRAM_DQ_BITS/8-1:0]  dqm;
    // Shared data bus, each side drives only during its own burst
    wire  [`SDRAM_DQ_BITS-1:0]    dq;

    sdram_ctrl u_ctrl (
        .clk, .rst_n,
        .req, .req_write, .req_bank, .req_row, .req_col, .req_mask,
        .wr_data, .wr_next, .rd_valid, .rd_data, .busy, .init_done,
        .cs, .ras, .cas, .we, .a, .ba, .dqm, .dq
    );

    sdram_device u_device (
        .clk, .rst_n,
        .cs, .ras, .cas, .we, .a, .ba, .dqm, .dq
    );

endmodule

// ==== tb/sdram_subsys_tb.sv ====
`include "sdram_settings.svh"

module sdram_subsys_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_OPS      = 300;
    localparam int BURST        = `SDRAM_BURST;
    localparam int NBYTE        = `SDRAM_DQ_BITS / 8;
    localparam int ROWS         = 1 << `SDRAM_ROW_BITS;
    localparam int COLS         = 1 << `SDRAM_COL_BITS;
    localparam int MEM_BYTES    = `SDRAM_BANKS * ROWS * COLS * NBYTE;
    // Power-up wait plus precharge, two refreshes and mode load, with slack
    localparam int INIT_BUDGET  = `SDRAM_INIT_CYCLES + `SDRAM_TRP + 2 * `SDRAM_TRFC
                                  + `SDRAM_TMRD + 8;
    // Worst case per request, read path is the longer one
    localparam int OP_CYCLES    = `SDRAM_TRCD + `SDRAM_CAS_LAT + BURST + `SDRAM_TRP + 12;
    localparam longint TIMEOUT  = longint'(RESET_CYCLES + INIT_BUDGET + NUM_OPS * OP_CYCLES)
                                  * CLK_PERIOD;

    logic                         clk;
    logic                         rst_n;
    logic                         req;
    logic                         req_write;
    logic [`SDRAM_BA_BITS-1:0]    req_bank;
    logic [`SDRAM_ROW_BITS-1:0]   req_row;
    logic [`SDRAM_COL_BITS-1:0]   req_col;
    logic [NBYTE-1:0]             req_mask;
    logic [`SDRAM_DQ_BITS-1:0]    wr_data;
    logic                         wr_next;
    logic                         rd_valid;
    logic [`SDRAM_DQ_BITS-1:0]    rd_data;
    logic                         busy;
    logic                         init_done;

    // Reference memory, one entry per byte lane
    logic [7:0]                   ref_byte [MEM_BYTES];
    bit                           ref_written [MEM_BYTES];
    logic [31:0]                  lfsr_state;
    int                           n_writes;
    int                           n_reads;

    sdram_subsys sdram_subsys_i (
        .clk, .rst_n,
        .req, .req_write, .req_bank, .req_row, .req_col, .req_mask,
        .wr_data, .wr_next, .rd_valid, .rd_data, .busy, .init_done
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic int byte_index(input int bank, input int row, input int col,
                                      input int b);
        return ((bank * ROWS + row) * COLS + col) * NBYTE + b;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, msg, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // One random request, driven to completion and checked
    task automatic run_op();
        logic [31:0]               r;
        logic                      is_write;
        logic [1:0]                bank;
        logic [`SDRAM_ROW_BITS-1:0] row;
        logic [`SDRAM_COL_BITS-1:0] base;
        logic [NBYTE-1:0]          mask;
        logic [15:0]               words [BURST];
        int                        wcnt;
        int                        rcnt;
        int                        idx;
        bit                        done;
        take_bits(1, r);
        is_write = r[0];
        take_bits(2, r);
        bank = r[1:0];
        // Four rows and four burst bases keep collisions frequent
        take_bits(2, r);
        row = `SDRAM_ROW_BITS'(r[1:0]);
        take_bits(2, r);
        base = `SDRAM_COL_BITS'({r[1:0], 2'b00});
        take_bits(NBYTE, r);
        mask = r[NBYTE-1:0];
        for (int k = 0; k < BURST; k++) begin
            take_bits(16, r);
            words[k] = r[15:0];
        end
        @(posedge clk);
        #DRIVE_DLY;
        req       = 1'b1;
        req_write = is_write;
        req_bank  = bank;
        req_row   = row;
        req_col   = base;
        req_mask  = mask;
        wr_data   = words[0];
        wcnt = 0;
        rcnt = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            #DRIVE_DLY;
            req = 1'b0;
            // Next word goes up after each taken word
            if (wcnt < BURST) begin
                wr_data = words[wcnt];
            end
            @(negedge clk);
            check_value(init_done, 1, "init_done dropped after init");
            if (wr_next) begin
                wcnt++;
            end
            if (rd_valid) begin
                for (int b = 0; b < NBYTE && rcnt < BURST; b++) begin
                    idx = byte_index(bank, row, base + rcnt, b);
                    // Never-written bytes hold no known value
                    if (ref_written[idx]) begin
                        check_value(rd_data[b*8 +: 8], ref_byte[idx],
                            $sformatf("read bank %0d row %0d col %0d byte %0d",
                                      bank, row, base + rcnt, b));
                    end
                end
                rcnt++;
            end
            done = !busy;
        end
        check_value(wcnt, is_write ? BURST : 0, "wr_next pulse count");
        check_value(rcnt, is_write ? 0 : BURST, "rd_valid pulse count");
        if (is_write) begin
            n_writes++;
            // Masked lanes keep whatever the model held before
            for (int k = 0; k < BURST; k++) begin
                for (int b = 0; b < NBYTE; b++) begin
                    if (!mask[b]) begin
                        idx = byte_index(bank, row, base + k, b);
                        ref_byte[idx]    = words[k][b*8 +: 8];
                        ref_written[idx] = 1'b1;
                    end
                end
            end
        end else begin
            n_reads++;
        end
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish within the expected number of cycles");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int cycles;
        rst_n      = 1'b0;
        req        = 1'b0;
        req_write  = 1'b0;
        req_bank   = '0;
        req_row    = '0;
        req_col    = '0;
        req_mask   = '0;
        wr_data    = '0;
        lfsr_state = 32'h2ee2;
        n_writes   = 0;
        n_reads    = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        @(negedge clk);
        check_value(init_done, 0, "init_done high right after reset");
        check_value(busy, 0, "busy high right after reset");
        // Power-up sequence
        cycles = 0;
        while (!init_done && cycles < INIT_BUDGET) begin
            @(negedge clk);
            cycles++;
        end
        check_value(init_done, 1, "init_done within init budget");
        check_value(busy, 0, "busy at end of init");
        for (int i = 0; i < NUM_OPS; i++) begin
            run_op();
        end
        $display("%0d writes and %0d reads checked", n_writes, n_reads);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
